/* barrel_pkg.sv */
`default_nettype none

package barrel_pkg;

    // spawner lane index is 3 bits wide.
    localparam int MAX_LANES = 7;

    // column on the horizontal track.
    typedef logic [7:0] pos_t;

    typedef logic [2:0] lane_idx_t;

    typedef enum logic [0:0] {
        ST_IDLE     = 1'b0,
        ST_COOLDOWN = 1'b1
    } spawn_state_t;

endpackage

`default_nettype wire

/* barrel_lane_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface barrel_lane_if
    import barrel_pkg::*;
();

    logic req;      // spawn request.
    logic ack;      // lane taken, held until the barrel ends.
    pos_t pos;
    logic rolling;
    logic kill;     // one-cycle hit pulse.

    modport spawner (
        output req,
        input  ack
    );

    modport lane (
        input  req,
        input  kill,
        output ack,
        output pos,
        output rolling
    );

    modport judge (
        input  pos,
        input  rolling,
        output kill
    );

endinterface

`default_nettype wire

/* barrel_ctl.sv */
`timescale 1ns/100ps
`default_nettype none

module barrel_ctl
    import barrel_pkg::*;
#(
    parameter int BARRELS    = 5,
    parameter int DELAY_TIME = 20
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start_game,
    input  logic           animation,
    input  logic           key,
    barrel_lane_if.spawner lanes [BARRELS]
);

    spawn_state_t state, state_nxt;

    logic [BARRELS-1:0] req, req_nxt;
    logic [BARRELS-1:0] ack;
    logic [28:0]        delay_cnt, delay_cnt_nxt;
    lane_idx_t          free_idx;
    logic               free_found;
    logic               throw;
    logic               delay_done;

    genvar i;
    generate
        for (i = 0; i < BARRELS; i++) begin : g_lane
            assign ack[i]        = lanes[i].ack;
            assign lanes[i].req  = req[i];
        end
    endgenerate

    // lowest lane with neither req nor ack.
    always_comb begin : free_search_blk
        free_found = 1'b0;
        free_idx   = '0;
        for (int n = BARRELS - 1; n >= 0; n--) begin
            if (!req[n] && !ack[n]) begin
                free_found = 1'b1;
                free_idx   = lane_idx_t'(n);
            end
        end
    end

    assign throw      = (state == ST_IDLE) && key && start_game && !animation && free_found;
    assign delay_done = (delay_cnt == 29'(DELAY_TIME - 1));

    always_comb begin : state_comb_blk
        case (state)
            ST_IDLE: begin
                state_nxt = throw ? ST_COOLDOWN : ST_IDLE;
            end

            ST_COOLDOWN: begin
                state_nxt = delay_done ? ST_IDLE : ST_COOLDOWN;
            end

            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_comb begin : delay_comb_blk
        if (state == ST_COOLDOWN && !delay_done) begin
            delay_cnt_nxt = delay_cnt + 29'd1;
        end else begin
            delay_cnt_nxt = '0;
        end
    end

    // req drops once the mover has answered.
    always_comb begin : req_comb_blk
        req_nxt = req & ~ack;
        if (throw) begin
            req_nxt[free_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin : ctl_seq_blk
        if (rst) begin
            state     <= ST_IDLE;
            req       <= '0;
            delay_cnt <= '0;
        end else begin
            state     <= state_nxt;
            req       <= req_nxt;
            delay_cnt <= delay_cnt_nxt;
        end
    end

endmodule

`default_nettype wire

/* barrel_mover.sv */
`timescale 1ns/100ps
`default_nettype none

module barrel_mover
    import barrel_pkg::*;
#(
    parameter int STEP_CYCLES = 4,
    parameter int TRACK_LEN   = 16
) (
    input  logic        clk,
    input  logic        rst,
    barrel_lane_if.lane lane
);

    localparam int STEP_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    logic              busy;
    logic [STEP_W-1:0] step_cnt;
    pos_t              pos;
    logic              step_end;
    logic              track_end;

    assign step_end  = (step_cnt == STEP_W'(STEP_CYCLES - 1));
    assign track_end = (pos == pos_t'(TRACK_LEN - 1));

    always_ff @(posedge clk) begin : roll_blk
        if (rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            pos      <= '0;
        end else if (!busy) begin
            if (lane.req) begin
                busy     <= 1'b1;   // take the barrel.
                step_cnt <= '0;
                pos      <= '0;
            end
        end else if (lane.kill) begin
            busy     <= 1'b0;       // hit the player.
            step_cnt <= '0;
        end else if (step_end) begin
            step_cnt <= '0;
            if (track_end) begin
                busy <= 1'b0;       // rolled off the end.
            end else begin
                pos <= pos + pos_t'(1);
            end
        end else begin
            step_cnt <= step_cnt + STEP_W'(1);
        end
    end

    // ack spans the whole roll.
    assign lane.ack     = busy;
    assign lane.rolling = busy;
    assign lane.pos     = pos;

endmodule

`default_nettype wire

/* barrel_judge.sv */
`timescale 1ns/100ps
`default_nettype none

module barrel_judge
    import barrel_pkg::*;
#(
    parameter int BARRELS = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         jump,
    input  pos_t         player_pos,
    barrel_lane_if.judge lanes [BARRELS],
    output logic         game_over,
    output logic [7:0]   score
);

    logic [BARRELS-1:0] rolling;
    logic [BARRELS-1:0] hit;
    logic [BARRELS-1:0] kill, kill_nxt;
    logic [BARRELS-1:0] passed, passed_nxt;
    logic [BARRELS-1:0] jumped;
    logic [7:0]         jump_cnt;

    genvar i;
    generate
        for (i = 0; i < BARRELS; i++) begin : g_lane
            assign rolling[i]     = lanes[i].rolling;
            assign hit[i]         = lanes[i].rolling && (lanes[i].pos == player_pos);
            assign lanes[i].kill  = kill[i];
        end
    endgenerate

    // a kill lasts one cycle, the lane is gone after it.
    assign kill_nxt   = hit & ~kill & {BARRELS{!jump}};
    assign jumped     = hit & ~passed & {BARRELS{jump}};
    assign passed_nxt = rolling & (passed | jumped);

    always_comb begin : jump_count_blk
        jump_cnt = '0;
        for (int n = 0; n < BARRELS; n++) begin
            jump_cnt = jump_cnt + {7'd0, jumped[n]};
        end
    end

    always_ff @(posedge clk) begin : judge_seq_blk
        if (rst) begin
            kill      <= '0;
            passed    <= '0;
            game_over <= 1'b0;
            score     <= '0;
        end else begin
            kill   <= kill_nxt;
            passed <= passed_nxt;
            score  <= score + jump_cnt;
            if (|kill_nxt) begin
                game_over <= 1'b1;  // sticky until reset.
            end
        end
    end

endmodule

`default_nettype wire

/* barrel_game_top.sv */
`timescale 1ns/100ps
`default_nettype none

module barrel_game_top
    import barrel_pkg::*;
#(
    parameter int BARRELS     = 5,
    parameter int DELAY_TIME  = 20,
    parameter int STEP_CYCLES = 4,
    parameter int TRACK_LEN   = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_game,
    input  logic               animation,
    input  logic               key,
    input  logic               jump,
    input  pos_t               player_pos,
    output logic [BARRELS-1:0] lane_busy,
    output logic               game_over,
    output logic [7:0]         score
);

    logic start_allowed;

    barrel_lane_if lanes [BARRELS] ();

    generate
        if (BARRELS < 1 || BARRELS > MAX_LANES) begin : g_bad_barrels
            $error("BARRELS out of range");
        end
    endgenerate

    // no new throws once the player is hit.
    assign start_allowed = start_game && !game_over;

    barrel_ctl #(
        .BARRELS    (BARRELS),
        .DELAY_TIME (DELAY_TIME)
    ) u_barrel_ctl (
        .clk        (clk),
        .rst        (rst),
        .start_game (start_allowed),
        .animation  (animation),
        .key        (key),
        .lanes      (lanes)
    );

    genvar g;
    generate
        for (g = 0; g < BARRELS; g++) begin : g_mover
            barrel_mover #(
                .STEP_CYCLES (STEP_CYCLES),
                .TRACK_LEN   (TRACK_LEN)
            ) u_barrel_mover (
                .clk  (clk),
                .rst  (rst),
                .lane (lanes[g])
            );

            assign lane_busy[g] = lanes[g].rolling;
        end
    endgenerate

    barrel_judge #(
        .BARRELS (BARRELS)
    ) u_barrel_judge (
        .clk        (clk),
        .rst        (rst),
        .jump       (jump),
        .player_pos (player_pos),
        .lanes      (lanes),
        .game_over  (game_over),
        .score      (score)
    );

endmodule

`default_nettype wire

/* barrel_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module barrel_checker
    import barrel_pkg::*;
#(
    parameter int TRACK_LEN = 16
) (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic rolling,
    input logic kill,
    input pos_t pos
);

    // the mover only answers a pending request.
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    // a barrel ends only at the track end or after a kill.
    ack_released_at_end: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> ($past(kill) || ($past(pos) == pos_t'(TRACK_LEN - 1))))
        else $error("ack fell before the barrel finished");

    pos_on_track: assert property (@(posedge clk) disable iff (rst)
        pos < pos_t'(TRACK_LEN))
        else $error("barrel position beyond the track end");

    kill_one_cycle: assert property (@(posedge clk) disable iff (rst)
        kill |=> !kill)
        else $error("kill held longer than one cycle");

    kill_only_rolling: assert property (@(posedge clk) disable iff (rst)
        kill |-> rolling)
        else $error("kill on a lane with no barrel");

endmodule

bind barrel_mover barrel_checker #(
    .TRACK_LEN (TRACK_LEN)
) u_barrel_checker (
    .clk     (clk),
    .rst     (rst),
    .req     (lane.req),
    .ack     (lane.ack),
    .rolling (lane.rolling),
    .kill    (lane.kill),
    .pos     (lane.pos)
);

`default_nettype wire

/* tb_barrel_game.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_barrel_game
    import barrel_pkg::*;
();

    localparam int BARRELS      = 5;
    localparam int DELAY_TIME   = 20;
    localparam int STEP_CYCLES  = 8;    // 128-cycle rolls, so all five lanes fill.
    localparam int TRACK_LEN    = 16;
    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_SEED    = 4;
    localparam int RAND_POS     = 255;  // marker for a random off-track column.

    typedef struct {
        logic               rst;
        logic               key;
        logic               jump;
        int                 player_pos;
        logic               start_game;
        logic               animation;
        int                 hold;
        logic [BARRELS-1:0] exp_busy;
        logic               exp_over;
        logic [7:0]         exp_score;
    } row_t;

    logic               clk;
    logic               rst;
    logic               start_game;
    logic               animation;
    logic               key;
    logic               jump;
    pos_t               player_pos;
    logic [BARRELS-1:0] lane_busy;
    logic               game_over;
    logic [7:0]         score;

    row_t rows [$];
    int   watchdog_ns;
    logic table_ready;
    logic run_passed;
    logic fail_reported;

    barrel_game_top #(
        .BARRELS     (BARRELS),
        .DELAY_TIME  (DELAY_TIME),
        .STEP_CYCLES (STEP_CYCLES),
        .TRACK_LEN   (TRACK_LEN)
    ) u_barrel_game_top (
        .clk        (clk),
        .rst        (rst),
        .start_game (start_game),
        .animation  (animation),
        .key        (key),
        .jump       (jump),
        .player_pos (player_pos),
        .lane_busy  (lane_busy),
        .game_over  (game_over),
        .score      (score)
    );

    function automatic void announce_fail();
        fail_reported = 1'b1;
        $display(">>> FAIL");
    endfunction

    task automatic fail_run(input string reason);
        announce_fail();
        $fatal(1, "%s", reason);
    endtask

    task automatic add_row(input int r, input int k, input int j, input int p,
                           input int s, input int a, input int h,
                           input int eb, input int eo, input int es);
        row_t row;
        row.rst        = (r != 0);
        row.key        = (k != 0);
        row.jump       = (j != 0);
        row.player_pos = p;
        row.start_game = (s != 0);
        row.animation  = (a != 0);
        row.hold       = h;
        row.exp_busy   = BARRELS'(eb);
        row.exp_over   = (eo != 0);
        row.exp_score  = 8'(es);
        rows.push_back(row);
    endtask

    // expected values hold at the last edge of each row.
    task automatic build_table();
        //     rst key jmp pos       st an hold busy  over score
        add_row(0,  1,  0, RAND_POS, 1, 1,  3, 'h00, 0, 0);  // animation blocks.
        add_row(0,  1,  0, RAND_POS, 0, 0,  3, 'h00, 0, 0);  // game not started.
        add_row(0,  0,  0, RAND_POS, 1, 0,  1, 'h00, 0, 0);
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h01, 0, 0);  // lane 0 in 2 cycles.
        add_row(0,  1,  0, RAND_POS, 1, 0, 18, 'h01, 0, 0);  // cooldown, keys dropped.
        add_row(0,  0,  0, RAND_POS, 1, 0,  1, 'h01, 0, 0);
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h03, 0, 0);  // first key after cooldown.
        add_row(0,  0,  0, RAND_POS, 1, 0, 19, 'h03, 0, 0);
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h07, 0, 0);
        add_row(0,  0,  0, RAND_POS, 1, 0, 19, 'h07, 0, 0);
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h0f, 0, 0);
        add_row(0,  0,  0, RAND_POS, 1, 0, 19, 'h0f, 0, 0);
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h1f, 0, 0);  // all five busy.
        add_row(0,  0,  0, RAND_POS, 1, 0, 19, 'h1f, 0, 0);
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h1f, 0, 0);  // no free lane.
        add_row(0,  0,  0, RAND_POS, 1, 0, 22, 'h1f, 0, 0);
        add_row(0,  0,  0, RAND_POS, 1, 0,  1, 'h1e, 0, 0);  // lane 0 rolled off.
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h1f, 0, 0);  // lane 0 reused.
        add_row(0,  0,  1, 14,       1, 0, 13, 'h1f, 0, 1);  // lane 1 jumped once.
        add_row(0,  0,  1, 14,       1, 0, 20, 'h1d, 0, 2);  // lane 2 jumped.
        add_row(0,  0,  0, 14,       1, 0,  8, 'h19, 0, 2);
        add_row(0,  0,  0, 14,       1, 0,  6, 'h11, 1, 2);  // lane 3 hits, freed early.
        add_row(0,  1,  0, RAND_POS, 1, 0,  3, 'h11, 1, 2);  // spawns blocked.
        add_row(0,  0,  0, RAND_POS, 1, 0, 40, 'h01, 1, 2);
        add_row(0,  1,  0, RAND_POS, 1, 0,  3, 'h01, 1, 2);
        add_row(1,  0,  0, RAND_POS, 1, 0,  5, 'h00, 0, 0);  // reset clears all.
        add_row(0,  1,  0, RAND_POS, 1, 0,  2, 'h01, 0, 0);
    endtask

    task automatic apply_row(input row_t row);
        rst        = row.rst;
        key        = row.key;
        jump       = row.jump;
        start_game = row.start_game;
        animation  = row.animation;
        if (row.player_pos == RAND_POS) begin
            player_pos = pos_t'($urandom_range(255, TRACK_LEN));
        end else begin
            player_pos = pos_t'(row.player_pos);
        end
    endtask

    task automatic check_row(input int idx, input row_t row);
        assert (lane_busy === row.exp_busy) else begin
            $display("MISMATCH lane_busy in row %0d: got 0x%h, expected 0x%h",
                     idx, lane_busy, row.exp_busy);
            fail_run("lane_busy check failed");
        end
        assert (game_over === row.exp_over) else begin
            $display("MISMATCH game_over in row %0d: got 0x%h, expected 0x%h",
                     idx, game_over, row.exp_over);
            fail_run("game_over check failed");
        end
        assert (score === row.exp_score) else begin
            $display("MISMATCH score in row %0d: got 0x%h, expected 0x%h",
                     idx, score, row.exp_score);
            fail_run("score check failed");
        end
    endtask

    initial begin : clk_blk
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : stim_blk
        int total_cycles;
        rst           = 1'b1;
        start_game    = 1'b0;
        animation     = 1'b0;
        key           = 1'b0;
        jump          = 1'b0;
        player_pos    = '0;
        table_ready   = 1'b0;
        run_passed    = 1'b0;
        fail_reported = 1'b0;
        void'($urandom(RAND_SEED));
        build_table();
        total_cycles = RESET_CYCLES;
        foreach (rows[n]) begin
            total_cycles += rows[n].hold;
        end
        watchdog_ns = (total_cycles + 100) * CLK_PERIOD;
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        foreach (rows[n]) begin
            apply_row(rows[n]);
            repeat (rows[n].hold) @(posedge clk);
            #DRIVE_DELAY;
            check_row(n, rows[n]);
        end
        run_passed = 1'b1;
        $display(">>> PASS");
        $finish;
    end

    initial begin : watchdog_blk
        wait (table_ready === 1'b1);
        #(watchdog_ns);
        $display("timeout: stimulus table still running after %0d ns", watchdog_ns);
        fail_run("watchdog expired");
    end

    final begin
        if (!run_passed && !fail_reported) begin
            announce_fail();
        end
    end

endmodule

`default_nettype wire

/* sim.f */
barrel_pkg.sv
barrel_lane_if.sv
barrel_ctl.sv
barrel_mover.sv
barrel_judge.sv
barrel_game_top.sv
barrel_checker.sv
tb_barrel_game.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_barrel_game
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
